/* flist.f */
gat_pkg.sv
gat_if.sv
gat_ctrl.sv
gat_entry_counter.sv
gat_weight_store.sv
gat_spmm_acc.sv
gat_attn_dot.sv
gat_top.sv
tb_gat_top.sv

/* tb_gat_top.sv */
`timescale 1ns/10ps

module tb_gat_top;

  localparam int NIN             = gat_pkg::NUM_FEATURE_IN;
  localparam int NOUT            = gat_pkg::NUM_FEATURE_OUT;
  localparam int DEPTH           = gat_pkg::WEIGHT_DEPTH;
  localparam int NUM_TESTS       = 5;
  localparam int MAX_TEST_CYCLES = 400;
  localparam int CLK_PERIOD      = 10;

  logic                                  clk = 1'b0;
  logic                                  rst_n;
  logic                                  h_valid_i;
  logic                                  h_ready_o;
  logic [gat_pkg::H_WORD_WIDTH-1:0]      h_word_i;
  logic                                  wh_valid_o;
  logic                                  wh_ready_i;
  logic                                  wh_flag_o;
  gat_pkg::wh_row_t                      wh_data_o;
  logic signed [gat_pkg::COEF_WIDTH-1:0] coef_self_o;
  logic signed [gat_pkg::COEF_WIDTH-1:0] coef_nbr_o;
  logic                                  wgt_wr_en_i;
  logic [gat_pkg::WEIGHT_ADDR_W-1:0]     wgt_addr_i;
  logic signed [gat_pkg::DATA_WIDTH-1:0] wgt_data_i;

  logic [15:0]       lfsr_q = 16'd79;
  logic signed [7:0] w_mem [NIN][NOUT];
  logic signed [7:0] a_self [NOUT];
  logic signed [7:0] a_nbr [NOUT];

  logic [gat_pkg::H_WORD_WIDTH-1:0] stream_q [$];
  gat_pkg::wh_row_t exp_data [$];
  gat_pkg::wh_row_t got_data [$];
  logic             exp_flag [$];
  logic             got_flag [$];
  int               exp_self [$];
  int               got_self [$];
  int               exp_nbr [$];
  int               got_nbr [$];

  int err_count   = 0;
  int check_count = 0;
  int test_count  = 0;

  gat_top dut_i (
    .clk         (clk        ),
    .rst_n       (rst_n      ),
    .h_valid_i   (h_valid_i  ),
    .h_ready_o   (h_ready_o  ),
    .h_word_i    (h_word_i   ),
    .wh_valid_o  (wh_valid_o ),
    .wh_ready_i  (wh_ready_i ),
    .wh_flag_o   (wh_flag_o  ),
    .wh_data_o   (wh_data_o  ),
    .coef_self_o (coef_self_o),
    .coef_nbr_o  (coef_nbr_o ),
    .wgt_wr_en_i (wgt_wr_en_i),
    .wgt_addr_i  (wgt_addr_i ),
    .wgt_data_i  (wgt_data_i )
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Taps 16, 14, 13, 11
  function automatic logic lfsr_bit();
    logic fb;
    fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    lfsr_q = {lfsr_q[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  // Output rows are taken on the edge after a negedge that sees valid and ready
  always @(negedge clk) begin
    if (rst_n && wh_valid_o && wh_ready_i) begin
      got_data.push_back(wh_data_o);
      got_flag.push_back(wh_flag_o);
      got_self.push_back(coef_self_o);
      got_nbr.push_back(coef_nbr_o);
    end
  end

  initial begin
    #(NUM_TESTS * MAX_TEST_CYCLES * CLK_PERIOD * 2);
    $display("watchdog expired, the run did not complete in time");
    $display("Finished with errors");
    $finish;
  end

  task automatic load_weights();
    logic signed [7:0] v;
    for (int addr = 0; addr < DEPTH; addr++) begin
      v = take_bits(8);
      if (addr < NIN * NOUT) begin
        w_mem[addr / NOUT][addr % NOUT] = v;
      end else if (addr < NIN * NOUT + NOUT) begin
        a_self[addr - NIN * NOUT] = v;
      end else begin
        a_nbr[addr - NIN * NOUT - NOUT] = v;
      end
      @(posedge clk);
      wgt_wr_en_i <= 1'b1;
      wgt_addr_i  <= addr[gat_pkg::WEIGHT_ADDR_W-1:0];
      wgt_data_i  <= v;
    end
    @(posedge clk);
    wgt_wr_en_i <= 1'b0;
  endtask

  // Queues the words of one row and the reference result for it
  task automatic add_row(input int len, input logic flag);
    int                 acc [NOUT];
    logic [3:0]         col;
    logic [3:0]         first_col;
    logic signed [7:0]  val;
    logic signed [19:0] whs;
    int                 sum_self;
    int                 sum_nbr;
    gat_pkg::wh_row_t   row;
    for (int j = 0; j < NOUT; j++) begin
      acc[j] = 0;
    end
    stream_q.push_back({7'd0, len[4:0], flag});
    for (int k = 0; k < len; k++) begin
      col = take_bits(4);
      val = take_bits(8);
      if (k == 0) begin
        first_col = col;
      end else if (k == len - 1) begin
        // Repeated column
        col = first_col;
      end
      stream_q.push_back({1'b0, col, val});
      for (int j = 0; j < NOUT; j++) begin
        acc[j] = acc[j] + val * w_mem[col][j];
      end
    end
    sum_self = 0;
    sum_nbr  = 0;
    for (int j = 0; j < NOUT; j++) begin
      whs      = acc[j][19:0];
      row[j]   = whs;
      sum_self = sum_self + whs * a_self[j];
      sum_nbr  = sum_nbr + whs * a_nbr[j];
    end
    exp_data.push_back(row);
    exp_flag.push_back(flag);
    exp_self.push_back(sum_self);
    exp_nbr.push_back(sum_nbr);
  endtask

  task automatic send_word(input logic [gat_pkg::H_WORD_WIDTH-1:0] w);
    h_valid_i <= 1'b1;
    h_word_i  <= w;
    @(negedge clk);
    while (!h_ready_o) begin
      @(negedge clk);
    end
    @(posedge clk);
  endtask

  // Returns right after the edge that takes the last word
  task automatic stream_words();
    @(posedge clk);
    while (stream_q.size() > 0) begin
      send_word(stream_q.pop_front());
    end
    h_valid_i <= 1'b0;
  endtask

  task automatic wait_results();
    int waited;
    waited = 0;
    while (got_flag.size() < exp_flag.size() && waited < 100) begin
      @(negedge clk);
      waited++;
    end
    if (got_flag.size() < exp_flag.size()) begin
      $display("timed out waiting for %0d result rows", exp_flag.size() - got_flag.size());
      err_count++;
    end
  endtask

  task automatic compare_results();
    gat_pkg::wh_row_t g_data;
    gat_pkg::wh_row_t e_data;
    int               g_self;
    int               e_self;
    int               g_nbr;
    int               e_nbr;
    logic             g_flag;
    logic             e_flag;
    while (exp_flag.size() > 0 && got_flag.size() > 0) begin
      g_data = got_data.pop_front();
      e_data = exp_data.pop_front();
      g_flag = got_flag.pop_front();
      e_flag = exp_flag.pop_front();
      g_self = got_self.pop_front();
      e_self = exp_self.pop_front();
      g_nbr  = got_nbr.pop_front();
      e_nbr  = exp_nbr.pop_front();
      check_count += 4;
      if (g_data !== e_data) begin
        $display("error: wh_data_o got %h expected %h", g_data, e_data);
        err_count++;
      end
      if (g_flag !== e_flag) begin
        $display("error: wh_flag_o got %h expected %h", g_flag, e_flag);
        err_count++;
      end
      if (g_self !== e_self) begin
        $display("error: coef_self_o got %h expected %h", g_self, e_self);
        err_count++;
      end
      if (g_nbr !== e_nbr) begin
        $display("error: coef_nbr_o got %h expected %h", g_nbr, e_nbr);
        err_count++;
      end
    end
    if (exp_flag.size() != 0 || got_flag.size() != 0) begin
      $display("row count mismatch, %0d expected rows never arrived, %0d extra rows arrived",
               exp_flag.size(), got_flag.size());
      err_count++;
    end
    exp_data.delete();
    exp_flag.delete();
    exp_self.delete();
    exp_nbr.delete();
    got_data.delete();
    got_flag.delete();
    got_self.delete();
    got_nbr.delete();
  endtask

  task automatic finish_test(input string name, input int start_errs);
    test_count++;
    if (err_count == start_errs) begin
      $display("%-18s ok", name);
    end else begin
      $display("%-18s failed with %0d errors", name, err_count - start_errs);
    end
  endtask

  task automatic test_reset();
    int start;
    start = err_count;
    @(negedge clk);
    check_count += 2;
    if (h_ready_o !== 1'b1) begin
      $display("error: h_ready_o got %h expected 1", h_ready_o);
      err_count++;
    end
    if (wh_valid_o !== 1'b0) begin
      $display("error: wh_valid_o got %h expected 0", wh_valid_o);
      err_count++;
    end
    finish_test("reset", start);
  endtask

  task automatic test_single_row();
    int start;
    start = err_count;
    load_weights();
    add_row(3, 1'b1);
    stream_words();
    wait_results();
    compare_results();
    finish_test("single row", start);
  endtask

  task automatic test_random_rows();
    int start;
    start = err_count;
    for (int i = 0; i < 10; i++) begin
      add_row(take_bits(3) + 1, i[0]);
    end
    stream_words();
    wait_results();
    compare_results();
    finish_test("random rows", start);
  endtask

  task automatic test_zero_row();
    int start;
    int cycles;
    start  = err_count;
    cycles = 0;
    add_row(0, 1'b0);
    stream_words();
    do begin
      @(negedge clk);
      cycles++;
    end while (!wh_valid_o && cycles < 20);
    check_count++;
    if (!wh_valid_o) begin
      $display("wh_valid_o never rose after a zero-length header");
      err_count++;
    end else if (cycles != 4) begin
      $display("error: wh_valid_o latency got %h expected %h", cycles, 4);
      err_count++;
    end
    wait_results();
    compare_results();
    finish_test("zero-length row", start);
  endtask

  task automatic test_backpressure();
    int               start;
    logic             held_valid;
    gat_pkg::wh_row_t held;
    start      = err_count;
    held_valid = 1'b0;
    for (int i = 0; i < 4; i++) begin
      add_row(take_bits(1) + 1, i[0]);
    end
    @(posedge clk);
    wh_ready_i <= 1'b0;
    fork
      stream_words();
      begin
        repeat (20) begin
          @(negedge clk);
          if (wh_valid_o && !held_valid) begin
            held_valid = 1'b1;
            held       = wh_data_o;
          end else if (held_valid && wh_data_o !== held) begin
            $display("error: wh_data_o got %h expected %h", wh_data_o, held);
            err_count++;
          end
        end
        check_count += 2;
        if (h_ready_o !== 1'b0) begin
          $display("error: h_ready_o got %h expected 0", h_ready_o);
          err_count++;
        end
        if (wh_valid_o !== 1'b1) begin
          $display("error: wh_valid_o got %h expected 1", wh_valid_o);
          err_count++;
        end
        @(posedge clk);
        wh_ready_i <= 1'b1;
      end
    join
    wait_results();
    compare_results();
    finish_test("back-pressure", start);
  endtask

  initial begin
    rst_n       = 1'b0;
    h_valid_i   = 1'b0;
    h_word_i    = '0;
    wh_ready_i  = 1'b1;
    wgt_wr_en_i = 1'b0;
    wgt_addr_i  = '0;
    wgt_data_i  = '0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    test_reset();
    test_single_row();
    test_random_rows();
    test_zero_row();
    test_backpressure();

    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* gat_top.sv */
`timescale 1ns/10ps

module gat_top #(
  parameter int NUM_FEATURE_IN  = gat_pkg::NUM_FEATURE_IN,
  parameter int NUM_FEATURE_OUT = gat_pkg::NUM_FEATURE_OUT
) (
  input  logic                                  clk,
  input  logic                                  rst_n,

  input  logic                                  h_valid_i,
  output logic                                  h_ready_o,
  input  logic [gat_pkg::H_WORD_WIDTH-1:0]      h_word_i,

  output logic                                  wh_valid_o,
  input  logic                                  wh_ready_i,
  output logic                                  wh_flag_o,
  output gat_pkg::wh_row_t                      wh_data_o,
  output logic signed [gat_pkg::COEF_WIDTH-1:0] coef_self_o,
  output logic signed [gat_pkg::COEF_WIDTH-1:0] coef_nbr_o,

  input  logic                                  wgt_wr_en_i,
  input  logic [gat_pkg::WEIGHT_ADDR_W-1:0]     wgt_addr_i,
  input  logic signed [gat_pkg::DATA_WIDTH-1:0] wgt_data_i
);

  logic                              load;
  logic                              acc;
  logic                              clear;
  logic                              rem_zero;
  logic                              rem_last;
  logic [gat_pkg::COL_IDX_WIDTH-1:0] rd_col;
  gat_pkg::w_row_t                   w_row;
  gat_pkg::w_row_t                   a_self;
  gat_pkg::w_row_t                   a_nbr;

  wh_row_if row_if ();

  gat_ctrl u_ctrl (
    .clk        (clk        ),
    .rst_n      (rst_n      ),
    .h_valid_i  (h_valid_i  ),
    .rem_zero_i (rem_zero   ),
    .rem_last_i (rem_last   ),
    .h_ready_o  (h_ready_o  ),
    .load_o     (load       ),
    .acc_o      (acc        ),
    .clear_o    (clear      ),
    .row_if     (row_if.ctrl)
  );

  gat_entry_counter u_entry_counter (
    .clk        (clk        ),
    .rst_n      (rst_n      ),
    .load_i     (load       ),
    .dec_i      (acc        ),
    .h_word_i   (h_word_i   ),
    .rem_zero_o (rem_zero   ),
    .rem_last_o (rem_last   )
  );

  gat_weight_store #(
    .NUM_FEATURE_IN  (NUM_FEATURE_IN ),
    .NUM_FEATURE_OUT (NUM_FEATURE_OUT)
  ) u_weight_store (
    .clk       (clk        ),
    .rst_n     (rst_n      ),
    .wr_en_i   (wgt_wr_en_i),
    .wr_addr_i (wgt_addr_i ),
    .wr_data_i (wgt_data_i ),
    .rd_col_i  (rd_col     ),
    .w_row_o   (w_row      ),
    .a_self_o  (a_self     ),
    .a_nbr_o   (a_nbr      )
  );

  gat_spmm_acc #(
    .NUM_FEATURE_OUT (NUM_FEATURE_OUT)
  ) u_spmm_acc (
    .clk      (clk       ),
    .rst_n    (rst_n     ),
    .h_word_i (h_word_i  ),
    .clear_i  (clear     ),
    .acc_i    (acc       ),
    .w_row_i  (w_row     ),
    .rd_col_o (rd_col    ),
    .row_if   (row_if.acc)
  );

  gat_attn_dot #(
    .NUM_FEATURE_OUT (NUM_FEATURE_OUT)
  ) u_attn_dot (
    .clk         (clk        ),
    .rst_n       (rst_n      ),
    .a_self_i    (a_self     ),
    .a_nbr_i     (a_nbr      ),
    .wh_ready_i  (wh_ready_i ),
    .row_if      (row_if.dst ),
    .wh_valid_o  (wh_valid_o ),
    .wh_flag_o   (wh_flag_o  ),
    .wh_data_o   (wh_data_o  ),
    .coef_self_o (coef_self_o),
    .coef_nbr_o  (coef_nbr_o )
  );

endmodule

/* gat_attn_dot.sv */
`timescale 1ns/10ps

module gat_attn_dot #(
  parameter int NUM_FEATURE_OUT = gat_pkg::NUM_FEATURE_OUT
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  gat_pkg::w_row_t                       a_self_i,
  input  gat_pkg::w_row_t                       a_nbr_i,
  input  logic                                  wh_ready_i,
  wh_row_if.dst                                 row_if,
  output logic                                  wh_valid_o,
  output logic                                  wh_flag_o,
  output gat_pkg::wh_row_t                      wh_data_o,
  output logic signed [gat_pkg::COEF_WIDTH-1:0] coef_self_o,
  output logic signed [gat_pkg::COEF_WIDTH-1:0] coef_nbr_o
);

  logic                                  s1_vld_q;
  logic                                  s2_vld_q;
  logic                                  s1_free;
  logic                                  s2_free;
  logic                                  s1_flag_q;
  gat_pkg::wh_row_t                      s1_row_q;
  logic signed [gat_pkg::COEF_WIDTH-1:0] self_d [NUM_FEATURE_OUT];
  logic signed [gat_pkg::COEF_WIDTH-1:0] nbr_d  [NUM_FEATURE_OUT];
  logic signed [gat_pkg::COEF_WIDTH-1:0] self_q [NUM_FEATURE_OUT];
  logic signed [gat_pkg::COEF_WIDTH-1:0] nbr_q  [NUM_FEATURE_OUT];
  logic signed [gat_pkg::COEF_WIDTH-1:0] sum_self;
  logic signed [gat_pkg::COEF_WIDTH-1:0] sum_nbr;

  // A stage may load when it is empty or its content leaves this cycle
  assign s2_free      = !s2_vld_q || wh_ready_i;
  assign s1_free      = !s1_vld_q || s2_free;
  assign row_if.ready = s1_free;

  always_comb begin
    for (int j = 0; j < NUM_FEATURE_OUT; j++) begin
      self_d[j] = $signed(row_if.data[j]) * $signed(a_self_i[j]);
      nbr_d[j]  = $signed(row_if.data[j]) * $signed(a_nbr_i[j]);
    end
  end

  always_comb begin
    sum_self = '0;
    sum_nbr  = '0;
    for (int j = 0; j < NUM_FEATURE_OUT; j++) begin
      sum_self = sum_self + self_q[j];
      sum_nbr  = sum_nbr + nbr_q[j];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_vld_q <= 1'b0;
      s2_vld_q <= 1'b0;
    end else begin
      if (s1_free) begin
        s1_vld_q <= row_if.valid;
      end
      if (s2_free) begin
        s2_vld_q <= s1_vld_q;
      end
    end
  end

  // Stage one, element products
  always_ff @(posedge clk) begin
    if (s1_free && row_if.valid) begin
      s1_flag_q <= row_if.flag;
      s1_row_q  <= row_if.data;
      self_q    <= self_d;
      nbr_q     <= nbr_d;
    end
  end

  // Stage two, reduced terms beside the row
  always_ff @(posedge clk) begin
    if (s2_free && s1_vld_q) begin
      wh_flag_o   <= s1_flag_q;
      wh_data_o   <= s1_row_q;
      coef_self_o <= sum_self;
      coef_nbr_o  <= sum_nbr;
    end
  end

  assign wh_valid_o = s2_vld_q;

endmodule

/* gat_spmm_acc.sv */
`timescale 1ns/10ps

module gat_spmm_acc #(
  parameter int NUM_FEATURE_OUT = gat_pkg::NUM_FEATURE_OUT
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  gat_pkg::h_word_u                  h_word_i,
  input  logic                              clear_i,
  input  logic                              acc_i,
  input  gat_pkg::w_row_t                   w_row_i,
  output logic [gat_pkg::COL_IDX_WIDTH-1:0] rd_col_o,
  wh_row_if.acc                             row_if
);

  gat_pkg::wh_row_t                         acc_q;
  logic                                     flag_q;
  logic signed [gat_pkg::WH_DATA_WIDTH-1:0] prod [NUM_FEATURE_OUT];

  // Column selects the W row in the weight store
  assign rd_col_o = h_word_i.entry.col;

  always_comb begin
    for (int j = 0; j < NUM_FEATURE_OUT; j++) begin
      prod[j] = $signed(h_word_i.entry.value) * $signed(w_row_i[j]);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q  <= '0;
      flag_q <= 1'b0;
    end else if (clear_i) begin
      acc_q  <= '0;
      flag_q <= h_word_i.header.flag;
    end else if (acc_i) begin
      // Sums wrap at the element width
      for (int j = 0; j < NUM_FEATURE_OUT; j++) begin
        acc_q[j] <= acc_q[j] + prod[j];
      end
    end
  end

  assign row_if.data = acc_q;
  assign row_if.flag = flag_q;

endmodule

/* gat_weight_store.sv */
`timescale 1ns/10ps

module gat_weight_store #(
  parameter int NUM_FEATURE_IN  = gat_pkg::NUM_FEATURE_IN,
  parameter int NUM_FEATURE_OUT = gat_pkg::NUM_FEATURE_OUT
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 wr_en_i,
  input  logic [gat_pkg::WEIGHT_ADDR_W-1:0]    wr_addr_i,
  input  logic signed [gat_pkg::DATA_WIDTH-1:0] wr_data_i,
  input  logic [gat_pkg::COL_IDX_WIDTH-1:0]    rd_col_i,
  output gat_pkg::w_row_t                      w_row_o,
  output gat_pkg::w_row_t                      a_self_o,
  output gat_pkg::w_row_t                      a_nbr_o
);

  localparam int A_BASE = NUM_FEATURE_IN * NUM_FEATURE_OUT;
  localparam int DEPTH  = A_BASE + 2 * NUM_FEATURE_OUT;

  logic signed [gat_pkg::DATA_WIDTH-1:0] mem [DEPTH];

  // Unloaded words read as zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_en_i && (int'(wr_addr_i) < DEPTH)) begin
      mem[wr_addr_i] <= wr_data_i;
    end
  end

  // Whole W row for one input column, plus both halves of a
  always_comb begin
    w_row_o  = '0;
    a_self_o = '0;
    a_nbr_o  = '0;
    for (int j = 0; j < NUM_FEATURE_OUT; j++) begin
      w_row_o[j]  = mem[int'(rd_col_i) * NUM_FEATURE_OUT + j];
      a_self_o[j] = mem[A_BASE + j];
      a_nbr_o[j]  = mem[A_BASE + NUM_FEATURE_OUT + j];
    end
  end

endmodule

/* gat_entry_counter.sv */
`timescale 1ns/10ps

module gat_entry_counter (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             load_i,
  input  logic             dec_i,
  input  gat_pkg::h_word_u h_word_i,
  output logic             rem_zero_o,
  output logic             rem_last_o
);

  // Entries still expected in the current row
  logic [gat_pkg::ROW_LEN_WIDTH-1:0] rem_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rem_q <= '0;
    end else if (load_i) begin
      rem_q <= h_word_i.header.row_len;
    end else if (dec_i) begin
      rem_q <= rem_q - 1'b1;
    end
  end

  assign rem_zero_o = (rem_q == '0);
  assign rem_last_o = (rem_q == 1);

endmodule

/* gat_ctrl.sv */
`timescale 1ns/10ps

module gat_ctrl (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   h_valid_i,
  input  logic   rem_zero_i,
  input  logic   rem_last_i,
  output logic   h_ready_o,
  output logic   load_o,
  output logic   acc_o,
  output logic   clear_o,
  wh_row_if.ctrl row_if
);

  localparam logic [1:0] ST_HEADER  = 2'd0;
  localparam logic [1:0] ST_ENTRIES = 2'd1;
  localparam logic [1:0] ST_EMIT    = 2'd2;

  logic [1:0] state_q;
  logic [1:0] state_d;
  logic       take;

  // No word is taken while a zero count is being seen
  always_comb begin
    case (state_q)
      ST_HEADER:  h_ready_o = 1'b1;
      ST_ENTRIES: h_ready_o = !rem_zero_i;
      default:    h_ready_o = 1'b0;
    endcase
  end

  assign take         = h_valid_i && h_ready_o;
  assign load_o       = take && (state_q == ST_HEADER);
  assign clear_o      = load_o;
  assign acc_o        = take && (state_q == ST_ENTRIES);
  assign row_if.valid = (state_q == ST_EMIT);

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_HEADER: begin
        if (take) begin
          state_d = ST_ENTRIES;
        end
      end
      ST_ENTRIES: begin
        if (rem_zero_i || (take && rem_last_i)) begin
          state_d = ST_EMIT;
        end
      end
      ST_EMIT: begin
        if (row_if.ready) begin
          state_d = ST_HEADER;
        end
      end
      default: state_d = ST_HEADER;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_HEADER;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

/* gat_if.sv */
`timescale 1ns/10ps

// Finished Wh row moving from the accumulator to the attention pipeline
interface wh_row_if;

  logic             valid;
  logic             ready;
  logic             flag;
  gat_pkg::wh_row_t data;

  modport ctrl (
    output valid,
    input  ready
  );

  modport acc (
    output flag,
    output data
  );

  modport dst (
    input  valid,
    input  flag,
    input  data,
    output ready
  );

endinterface

/* gat_pkg.sv */
package gat_pkg;

  // Layer sizes
  localparam int NUM_FEATURE_IN  = 16;
  localparam int NUM_FEATURE_OUT = 4;

  localparam int DATA_WIDTH      = 8;
  localparam int WH_DATA_WIDTH   = 20;
  localparam int COEF_WIDTH      = 32;

  localparam int COL_IDX_WIDTH   = $clog2(NUM_FEATURE_IN);
  localparam int ROW_LEN_WIDTH   = $clog2(NUM_FEATURE_IN + 1);

  // W rows first, then a_self, then a_nbr
  localparam int WEIGHT_DEPTH    = NUM_FEATURE_IN * NUM_FEATURE_OUT + 2 * NUM_FEATURE_OUT;
  localparam int WEIGHT_ADDR_W   = $clog2(WEIGHT_DEPTH);

  localparam int H_WORD_WIDTH    = 13;

  typedef logic [NUM_FEATURE_OUT-1:0][WH_DATA_WIDTH-1:0] wh_row_t;
  typedef logic [NUM_FEATURE_OUT-1:0][DATA_WIDTH-1:0]    w_row_t;

  // First word of a row
  typedef struct packed {
    logic [H_WORD_WIDTH-ROW_LEN_WIDTH-2:0] pad;
    logic [ROW_LEN_WIDTH-1:0]              row_len;
    logic                                  flag;
  } h_header_t;

  // One nonzero of the sparse row
  typedef struct packed {
    logic [H_WORD_WIDTH-COL_IDX_WIDTH-DATA_WIDTH-1:0] pad;
    logic [COL_IDX_WIDTH-1:0]                         col;
    logic signed [DATA_WIDTH-1:0]                     value;
  } h_entry_t;

  typedef union packed {
    h_header_t header;
    h_entry_t  entry;
  } h_word_u;

endpackage
